//--- hdl/fpgaSerializer.sv
`timescale 1ns/1ns
`include "pcUpstream_macros.svh"

// spikes and heartbeats out as word pairs on the FPGA channel
module fpgaSerializer import pcUpstreamPkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  spikeEventT         spikeEvent,
  input  logic               spikeValid,
  output logic               spikeAck,
  input  logic               hbStrobe,
  input  logic [`TIME_W-1:0] hbTime,
  output pcWordT             fpgaWord,
  output logic               fpgaValid,
  input  logic               fpgaAck
);

  serStateE           state;
  serStateE           nextState;
  // heartbeat waiting to be sent, with its time
  logic               hbPending;
  logic [`TIME_W-1:0] pendTime;
  // whatever is being serialized right now, event or time
  logic [`TIME_W-1:0] serBuf;
  spikeEventT         bufEvent;
  logic               xfer;
  logic               takeHb;
  logic               takeSpike;

  ////////////////////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////////////////////

  // only take a spike when idle and no heartbeat is queued
  assign spikeAck  = (state == SER_IDLE) && !hbPending;
  assign fpgaValid = (state != SER_IDLE);
  assign xfer      = fpgaValid && fpgaAck;
  // pending heartbeat goes first
  assign takeHb    = (state == SER_IDLE) && hbPending;
  assign takeSpike = spikeAck && spikeValid;
  assign bufEvent  = serBuf;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      SER_IDLE: begin
        if (takeHb) begin
          nextState = SER_HB_LO;
        end else if (takeSpike) begin
          nextState = SER_SPIKE_LO;
        end
      end
      // low word then high word, advance on each transfer
      SER_SPIKE_LO: if (xfer) nextState = SER_SPIKE_HI;
      SER_SPIKE_HI: if (xfer) nextState = SER_IDLE;
      SER_HB_LO:    if (xfer) nextState = SER_HB_HI;
      SER_HB_HI:    if (xfer) nextState = SER_IDLE;
      default:      nextState = SER_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SER_IDLE;
      hbPending <= 1'b0;
    end else begin
      state <= nextState;
      // a new strobe wins over the clear
      if (hbStrobe) begin
        hbPending <= 1'b1;
      end else if (takeHb) begin
        hbPending <= 1'b0;
      end
    end
  end

  // later strobe overwrites a time not yet sent
  always_ff @(posedge clk) begin
    if (hbStrobe) begin
      pendTime <= hbTime;
    end
    if (takeHb) begin
      serBuf <= pendTime;
    end else if (takeSpike) begin
      serBuf <= spikeEvent;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word formatting
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state)
      // high spike word: index, then top state bits
      SER_SPIKE_HI: begin
        fpgaWord.code    = CODE_SPIKE;
        fpgaWord.payload = {bufEvent.filtIdx, bufEvent.state[`SPIKE_STATE_W-1:`NPC_DATA]};
      end
      SER_HB_LO: begin
        fpgaWord.code    = CODE_HB_LO;
        fpgaWord.payload = serBuf[`NPC_DATA-1:0];
      end
      SER_HB_HI: begin
        fpgaWord.code    = CODE_HB_HI;
        fpgaWord.payload = serBuf[`TIME_W-1:`NPC_DATA];
      end
      // low spike word, also shown while idle
      default: begin
        fpgaWord.code    = CODE_SPIKE;
        fpgaWord.payload = bufEvent.state[`NPC_DATA-1:0];
      end
    endcase
  end

endmodule

//--- hdl/pcPacker.sv
`timescale 1ns/1ns

// merges BD and FPGA words into the PC stream
//
// codes tell the word sources apart, there is no BD/FPGA bit
// word pairs from the FPGA side may be split by a BD word
module pcPacker import pcUpstreamPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  pcWordT bdWord,
  input  logic   bdValid,
  output logic   bdAck,
  input  pcWordT fpgaWord,
  input  logic   fpgaValid,
  output logic   fpgaAck,
  output pcWordT pcWord,
  input  logic   pcAck,
  output logic   pcValid
);

  // single output slot
  pcWordT outSlot;
  logic   slotValid;
  // slot is free or drains this cycle
  logic   canLoad;
  // which side got the last grant
  logic   lastFpga;
  logic   bdTurn;
  logic   fpgaTurn;
  logic   bdXfer;
  logic   fpgaXfer;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  assign canLoad = !slotValid || pcAck;

  // a side may go if the other is idle or it is its turn
  assign bdTurn   = !fpgaValid || lastFpga;
  assign fpgaTurn = !bdValid || !lastFpga;

  // never both acks with both sides valid
  assign bdAck   = canLoad && bdTurn;
  assign fpgaAck = canLoad && fpgaTurn;

  assign bdXfer   = bdValid && bdAck;
  assign fpgaXfer = fpgaValid && fpgaAck;

  always_ff @(posedge clk) begin
    if (rst) begin
      lastFpga <= 1'b0;
    end else if (bdXfer) begin
      lastFpga <= 1'b0;
    end else if (fpgaXfer) begin
      lastFpga <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output slot
  ////////////////////////////////////////////////////////////////////////////

  // valid bit, held under back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      slotValid <= 1'b0;
    end else if (bdXfer || fpgaXfer) begin
      slotValid <= 1'b1;
    end else if (pcAck) begin
      // drained with nothing to refill
      slotValid <= 1'b0;
    end
  end

  // payload, loaded from whichever side transferred
  always_ff @(posedge clk) begin
    if (bdXfer) begin
      outSlot <= bdWord;
    end else if (fpgaXfer) begin
      outSlot <= fpgaWord;
    end
  end

  assign pcWord  = outSlot;
  assign pcValid = slotValid;

endmodule

//--- hdl/pcUpstreamPkg.sv
`include "pcUpstream_macros.svh"

package pcUpstreamPkg;

  ////////////////////////////////////////////////////////////////////////////
  // word and event types
  ////////////////////////////////////////////////////////////////////////////

  // one upstream word, code in the MSBs
  //    8      24
  // [ code | data ]
  typedef struct packed {
    logic [`NPC_CODE-1:0] code;
    logic [`NPC_DATA-1:0] payload;
  } pcWordT;

  // filtered spike/tag event, index above state
  typedef struct packed {
    logic [`SPIKE_IDX_W-1:0]   filtIdx;
    logic [`SPIKE_STATE_W-1:0] state;
  } spikeEventT;

  ////////////////////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////////////////////

  // FPGA word codes, BD codes 0..13 travel as raw values
  typedef enum logic [`NPC_CODE-1:0] {
    CODE_SPIKE = 8'd14,
    CODE_HB_LO = 8'd15,
    CODE_HB_HI = 8'd16
  } pcCodeE;

  // serializer FSM, one state per outgoing word
  typedef enum logic [2:0] {
    SER_IDLE,
    SER_SPIKE_LO,
    SER_SPIKE_HI,
    SER_HB_LO,
    SER_HB_HI
  } serStateE;

endpackage

//--- hdl/pcUpstreamTop.sv
`timescale 1ns/1ns
`include "pcUpstream_macros.svh"

// upstream path: time manager, FPGA serializer, packer
module pcUpstreamTop import pcUpstreamPkg::*; (
  input  logic       clk,
  input  logic       rst,
  // serialized BD traffic
  input  pcWordT     bdWord,
  input  logic       bdValid,
  output logic       bdAck,
  // filtered spike/tag events
  input  spikeEventT spikeEvent,
  input  logic       spikeValid,
  output logic       spikeAck,
  // merged stream towards the PC
  output pcWordT     pcWord,
  output logic       pcValid,
  input  logic       pcAck
);

  // heartbeat from the time manager
  logic               hbStrobe;
  logic [`TIME_W-1:0] hbTime;
  // serializer to packer channel
  pcWordT             fpgaWord;
  logic               fpgaValid;
  logic               fpgaAck;

  timeMgr timeMgrInst (
    .clk      (clk),
    .rst      (rst),
    .hbStrobe (hbStrobe),
    .hbTime   (hbTime)
  );

  fpgaSerializer fpgaSerializerInst (
    .clk        (clk),
    .rst        (rst),
    .spikeEvent (spikeEvent),
    .spikeValid (spikeValid),
    .spikeAck   (spikeAck),
    .hbStrobe   (hbStrobe),
    .hbTime     (hbTime),
    .fpgaWord   (fpgaWord),
    .fpgaValid  (fpgaValid),
    .fpgaAck    (fpgaAck)
  );

  pcPacker pcPackerInst (
    .clk       (clk),
    .rst       (rst),
    .bdWord    (bdWord),
    .bdValid   (bdValid),
    .bdAck     (bdAck),
    .fpgaWord  (fpgaWord),
    .fpgaValid (fpgaValid),
    .fpgaAck   (fpgaAck),
    .pcWord    (pcWord),
    .pcAck     (pcAck),
    .pcValid   (pcValid)
  );

endmodule

//--- hdl/pcUpstream_macros.svh
`ifndef PCUPSTREAM_MACROS_SVH
`define PCUPSTREAM_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// PC word format
////////////////////////////////////////////////////////////////////////////

// code field, shared by BD and FPGA words
`define NPC_CODE 8
// payload chunk carried by every word
`define NPC_DATA 24

////////////////////////////////////////////////////////////////////////////
// FPGA-side sources
////////////////////////////////////////////////////////////////////////////

// filter state is the DSP accumulator width
`define SPIKE_STATE_W 27
// remaining bits of the two-word event go to the filter index
`define SPIKE_IDX_W 21
// heartbeat time, split over two words
`define TIME_W 48
// cycles between heartbeats
`define HEARTBEAT_PERIOD 32'd64

`endif

//--- hdl/timeMgr.sv
`timescale 1ns/1ns
`include "pcUpstream_macros.svh"

// cycle time since reset plus a periodic heartbeat
module timeMgr (
  input  logic               clk,
  input  logic               rst,
  output logic               hbStrobe,
  output logic [`TIME_W-1:0] hbTime
);

  // free-running time, zero in the first cycle after reset
  logic [`TIME_W-1:0] cycleTime;
  // cycles left until the next multiple of the period
  logic [31:0]        periodCnt;
  logic               wrap;

  // periodCnt hits zero in the cycle before a multiple of the period
  assign wrap = (periodCnt == 32'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycleTime <= '0;
      periodCnt <= `HEARTBEAT_PERIOD - 32'd1;
      hbStrobe  <= 1'b0;
    end else begin
      cycleTime <= cycleTime + 1'b1;
      // reload on wrap, otherwise count down
      if (wrap) begin
        periodCnt <= `HEARTBEAT_PERIOD - 32'd1;
      end else begin
        periodCnt <= periodCnt - 32'd1;
      end
      // strobe lines up with the cycle whose time is the multiple
      hbStrobe <= wrap;
    end
  end

  // time stamp registered next to the strobe
  always_ff @(posedge clk) begin
    if (wrap) begin
      hbTime <= cycleTime + 1'b1;
    end
  end

endmodule

//--- project.f
+incdir+hdl
hdl/pcUpstreamPkg.sv
hdl/timeMgr.sv
hdl/fpgaSerializer.sv
hdl/pcPacker.sv
hdl/pcUpstreamTop.sv
verification/pcUpstreamTb.sv

//--- run.sh
#!/bin/sh
# build and run the upstream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module pcUpstreamTb -o pcUpstreamSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/pcUpstreamSim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
else
  exit 1
fi

//--- verification/pcUpstreamTb.sv
`timescale 1ns/1ns
`include "pcUpstream_macros.svh"

module pcUpstreamTb import pcUpstreamPkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // run length and limits
  ////////////////////////////////////////////////////////////////////////////

  localparam int bdWordTotal = 300;
  localparam int spikeTotal  = 150;
  // up to 32 cycles per expected PC word plus reset and drain margin
  localparam int cycleLimit  = (bdWordTotal + 2 * spikeTotal) * 32 + 800;
  // saturated window with both sources valid and pcAck high
  localparam int phaseStart  = 150;
  localparam int phaseLen    = 60;

  logic        clk;
  logic        rst;
  pcWordT      bdWord;
  logic        bdValid;
  logic        bdAck;
  spikeEventT  spikeEvent;
  logic        spikeValid;
  logic        spikeAck;
  pcWordT      pcWord;
  logic        pcValid;
  logic        pcAck;

  // scoreboard state
  pcWordT      bdQ[$];
  pcWordT      spikeQ[$];
  int          bdSent;
  int          spikeSent;
  int          cycleCount;
  int          runLen;
  int          phaseWords;
  logic        bdTaken;
  logic        spikeTaken;
  logic        seenInput;
  logic        holdCheck;
  pcWordT      heldWord;
  logic        lastWasBd;
  // heartbeat reassembly
  logic        hbLoSeen;
  logic [23:0] hbLoPayload;
  logic [47:0] lastHbTime;
  logic [31:0] rngState;

  pcUpstreamTop DUT (
    .clk        (clk),
    .rst        (rst),
    .bdWord     (bdWord),
    .bdValid    (bdValid),
    .bdAck      (bdAck),
    .spikeEvent (spikeEvent),
    .spikeValid (spikeValid),
    .spikeAck   (spikeAck),
    .pcWord     (pcWord),
    .pcValid    (pcValid),
    .pcAck      (pcAck)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] randomWord();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // low half carries state bits 23..0
  function automatic pcWordT lowSpikeWord(input spikeEventT ev);
    pcWordT w;
    w.code    = CODE_SPIKE;
    w.payload = ev.state[23:0];
    return w;
  endfunction

  // high half carries the index above state bits 26..24
  function automatic pcWordT highSpikeWord(input spikeEventT ev);
    pcWordT w;
    w.code    = CODE_SPIKE;
    w.payload = {ev.filtIdx, ev.state[26:24]};
    return w;
  endfunction

  task automatic abortRun();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [63:0] expVal,
                          input logic [63:0] actVal);
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
    abortRun();
  endtask

  task automatic complain(input string msg);
    $display("%s (at %0t ns)", msg, $time);
    abortRun();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output word routing by code
  ////////////////////////////////////////////////////////////////////////////

  task automatic routeOutputWord(input pcWordT w);
    pcWordT      expWord;
    logic [47:0] hbTime;
    if (w.code <= 8'd13) begin
      assert (bdQ.size() > 0) else complain("BD word came out that was never sent");
      expWord = bdQ.pop_front();
      assert (w == expWord) else mismatch("pcWord", 64'(expWord), 64'(w));
    end else if (w.code == CODE_SPIKE) begin
      // no spike word may split a heartbeat pair
      assert (!hbLoSeen) else complain("spike word between heartbeat low and high words");
      assert (spikeQ.size() > 0) else complain("spike word came out that was never sent");
      expWord = spikeQ.pop_front();
      assert (w == expWord) else mismatch("pcWord", 64'(expWord), 64'(w));
    end else if (w.code == CODE_HB_LO) begin
      assert (!hbLoSeen) else complain("two heartbeat low words without a high word");
      hbLoSeen    = 1'b1;
      hbLoPayload = w.payload;
    end else if (w.code == CODE_HB_HI) begin
      assert (hbLoSeen) else complain("heartbeat high word without a low word");
      hbTime = {w.payload, hbLoPayload};
      assert (hbTime != 48'd0 && (hbTime % `HEARTBEAT_PERIOD) == 48'd0)
        else complain("heartbeat time is not a nonzero multiple of the period");
      assert (hbTime > lastHbTime) else mismatch("hbTime", 64'(lastHbTime), 64'(hbTime));
      lastHbTime = hbTime;
      hbLoSeen   = 1'b0;
    end else begin
      complain("output word carries an unknown code");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sampling at the falling edge where every signal has settled
  ////////////////////////////////////////////////////////////////////////////

  task automatic sampleEdge();
    logic outXfer;
    logic fromBd;
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      complain("run did not finish within the cycle limit");
    end
    bdTaken    = bdValid && bdAck;
    spikeTaken = spikeValid && spikeAck;
    outXfer    = pcValid && pcAck;
    // nothing may leave before anything went in
    if (!seenInput) begin
      assert (pcValid == 1'b0) else mismatch("pcValid", 64'd0, 64'(pcValid));
    end
    // stalled slot must hold its word
    if (holdCheck) begin
      assert (pcValid == 1'b1) else mismatch("pcValid", 64'd1, 64'(pcValid));
      assert (pcWord == heldWord) else mismatch("pcWord", 64'(heldWord), 64'(pcWord));
    end
    // a stalled slot blocks both inputs
    if (pcValid && !pcAck) begin
      assert (bdAck == 1'b0) else mismatch("bdAck", 64'd0, 64'(bdAck));
      assert (DUT.fpgaAck == 1'b0) else mismatch("fpgaAck", 64'd0, 64'(DUT.fpgaAck));
    end
    holdCheck = pcValid && !pcAck;
    heldWord  = pcWord;
    if (outXfer) begin
      routeOutputWord(pcWord);
    end
    // fairness inside the saturated window
    if (outXfer && cycleCount >= phaseStart + 2 && cycleCount <= phaseStart + phaseLen) begin
      fromBd = (pcWord.code <= 8'd13);
      if (runLen > 0 && fromBd == lastWasBd) begin
        runLen++;
      end else begin
        runLen = 1;
      end
      lastWasBd = fromBd;
      phaseWords++;
      assert (runLen <= 2) else complain("one input won more than twice in a row");
    end else begin
      runLen = 0;
    end
    // the window has to carry real traffic
    if (cycleCount == phaseStart + phaseLen + 1) begin
      assert (phaseWords >= phaseLen / 2)
        else complain("saturated window produced too few words");
    end
    if (bdTaken) begin
      bdQ.push_back(bdWord);
      bdSent++;
    end
    if (spikeTaken) begin
      spikeQ.push_back(lowSpikeWord(spikeEvent));
      spikeQ.push_back(highSpikeWord(spikeEvent));
      spikeSent++;
    end
    seenInput = seenInput || bdTaken || (DUT.fpgaValid && DUT.fpgaAck);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus applied just after the rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic driveInputs();
    logic        inPhase;
    logic [31:0] r;
    logic [31:0] r2;
    inPhase = (cycleCount >= phaseStart) && (cycleCount < phaseStart + phaseLen);
    // a source holds its word until the handshake
    if (!bdValid || bdTaken) begin
      r = randomWord();
      if (bdSent < bdWordTotal && (inPhase || r[1:0] != 2'd0)) begin
        r2             = randomWord();
        bdWord.code    = r2[31:24] % 8'd14;
        bdWord.payload = r2[23:0];
        bdValid        = 1'b1;
      end else begin
        bdValid = 1'b0;
      end
    end
    if (!spikeValid || spikeTaken) begin
      r = randomWord();
      if (spikeSent < spikeTotal && (inPhase || r[0])) begin
        r                  = randomWord();
        r2                 = randomWord();
        spikeEvent.filtIdx = r[20:0];
        spikeEvent.state   = r2[26:0];
        spikeValid         = 1'b1;
      end else begin
        spikeValid = 1'b0;
      end
    end
    // roughly 70 percent ready outside the window
    r     = randomWord();
    pcAck = inPhase || ((r % 32'd10) < 32'd7);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    bdWord      = '0;
    bdValid     = 1'b0;
    spikeEvent  = '0;
    spikeValid  = 1'b0;
    pcAck       = 1'b0;
    rngState    = 32'h3e91_d8a2;
    bdSent      = 0;
    spikeSent   = 0;
    cycleCount  = 0;
    runLen      = 0;
    phaseWords  = 0;
    bdTaken     = 1'b0;
    spikeTaken  = 1'b0;
    seenInput   = 1'b0;
    holdCheck   = 1'b0;
    heldWord    = '0;
    lastWasBd   = 1'b0;
    hbLoSeen    = 1'b0;
    hbLoPayload = '0;
    lastHbTime  = '0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    // traffic until every word sent has come out
    while (!(bdSent == bdWordTotal && spikeSent == spikeTotal &&
             bdQ.size() == 0 && spikeQ.size() == 0)) begin
      @(negedge clk);
      sampleEdge();
      @(posedge clk);
      #1;
      driveInputs();
    end
    // idle tail catches duplicated words
    repeat (20) begin
      @(negedge clk);
      sampleEdge();
      @(posedge clk);
      #1;
      driveInputs();
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule
